// ==== src/snn_pkg.sv ====
/*
 * Shared definitions for the spiking network processor
 * network sizes, flag positions and potential widths
 * constant synaptic weight table
 * input and output packet structs
 */

package snn_pkg;

    // network dimensions
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 4;

    // prefix flags ahead of the spike bits
    localparam int NUM_FLG = 3;

    // flag positions, counted down from the packet msb
    localparam int RUN = 0;
    localparam int SNC = 1;
    localparam int CLR = 2;

    // packet word widths
    localparam int PKT_IN_WIDTH  = NUM_FLG + NUM_INP;
    localparam int PKT_OUT_WIDTH = NUM_FLG + NUM_OUT;

    // neuron arithmetic
    localparam int POT_WIDTH = 8;
    localparam int WGT_WIDTH = 4;

    // potential at or above this fires the neuron
    localparam logic signed [POT_WIDTH-1:0] THRESHOLD = 8'sd8;

    // one signed synaptic weight
    typedef logic signed [WGT_WIDTH-1:0] wgt_t;

    // weights indexed [neuron][input], input 0 listed first in each row
    // neuron 0 excites on every input
    // neuron 1 is dominated by input 0, inhibited by input 2
    // neuron 2 is inhibited by input 0
    // neuron 3 is inhibited by input 3
    localparam wgt_t WEIGHTS [NUM_OUT][NUM_INP] = '{
        '{ 4'sd3,  4'sd2,  4'sd1,  4'sd2},
        '{ 4'sd7,  4'sd1, -4'sd2,  4'sd0},
        '{-4'sd3,  4'sd4,  4'sd2,  4'sd1},
        '{ 4'sd1,  4'sd1,  4'sd1, -4'sd4}
    };

    // packet prefix, msb first: run, sync, clear
    typedef struct packed {
        logic run;
        logic snc;
        logic clr;
    } flags_t;

    // host to network packet
    // spikes[i] drives network input i
    typedef struct packed {
        flags_t                flg;
        logic [NUM_INP-1:0]    spikes;
    } in_pkt_t;

    // network to host packet
    // run flag is never set on the way out
    // spikes[i] is the output of neuron i
    typedef struct packed {
        flags_t                flg;
        logic [NUM_OUT-1:0]    spikes;
    } out_pkt_t;

endpackage

// ==== src/network_source.sv ====
/*
 * Input side of the network
 * accepts host packets over ready/valid
 * turns flags into clear, sync and step pulses
 * keeps the pending-result level net_en
 */

`timescale 1ns/1ps

module network_source
    import snn_pkg::*;
(
    input  logic                clk,
    input  logic                arstn,
    // host stream
    input  logic                src_valid,
    output logic                src_ready,
    input  in_pkt_t             src,
    // back-pressure from the sink
    input  logic                net_ready,
    // network drive
    output logic [NUM_INP-1:0]  net_spikes,
    output logic                net_step,
    output logic                net_sync,
    output logic                net_arstn,
    output logic                net_en
);

    // raw view of the packet with flags picked by position
    logic [PKT_IN_WIDTH-1:0] src_word;
    logic                    flg_run;
    logic                    flg_snc;
    logic                    flg_clr;

    // handshake on this edge
    logic                    accept;

    // a packet sits in its cycle after acceptance
    logic                    pkt_vld;

    // held low for the first cycle out of reset
    logic                    init_done;

    assign src_word = src;
    assign flg_run  = src_word[PKT_IN_WIDTH-1-RUN];
    assign flg_snc  = src_word[PKT_IN_WIDTH-1-SNC];
    assign flg_clr  = src_word[PKT_IN_WIDTH-1-CLR];

    // ready needs an open output path and no packet in flight
    // a waiting result always leaves on an edge with net_ready high
    assign src_ready = init_done && net_ready && !pkt_vld;
    assign accept    = src_valid && src_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    // flag pulses one cycle wide after acceptance
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pkt_vld   <= 1'b0;
            net_step  <= 1'b0;
            net_sync  <= 1'b0;
            net_arstn <= 1'b1;
        end else begin
            pkt_vld   <= accept;
            net_step  <= accept && flg_run;
            net_sync  <= accept && flg_snc;
            // active low clear toward the neurons
            net_arstn <= !(accept && flg_clr);
        end
    end

    // input spikes only matter while net_step is high
    always_ff @(posedge clk) begin
        if (accept) begin
            net_spikes <= src_word[NUM_INP-1:0];
        end
    end

    // result pending from the step edge until the output handshake
    // a step never lands on a handshake edge
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            net_en <= 1'b0;
        end else if (net_step) begin
            net_en <= 1'b1;
        end else if (net_ready) begin
            net_en <= 1'b0;
        end
    end

endmodule

// ==== src/lif_neuron.sv ====
/*
 * Integrate-and-fire neuron without leak
 * weighted sum of active inputs from its WEIGHTS row
 * threshold test, fire and reset to zero
 * potential clamped at zero from below
 */

`timescale 1ns/1ps

module lif_neuron
    import snn_pkg::*;
#(
    // row of WEIGHTS, 0 to NUM_OUT-1
    parameter int NRN_IDX = 0
) (
    input  logic                clk,
    input  logic                arstn,
    // network clear, active low, one cycle
    input  logic                net_arstn,
    // integrate strobe
    input  logic                net_step,
    input  logic [NUM_INP-1:0]  net_spikes,
    output logic                spike
);

    // either reset clears the neuron
    logic                        nrn_arstn;

    // stored potential, never negative after a step
    logic signed [POT_WIDTH-1:0] pot_q;

    // next potential before the threshold test
    logic signed [POT_WIDTH-1:0] pot_sum;

    // outcome of this step
    logic                        fire;
    logic signed [POT_WIDTH-1:0] pot_nxt;

    // both are glitch free, net_arstn comes straight from a flop
    assign nrn_arstn = arstn && net_arstn;

    // add the weight of every active input
    // worst case stays inside POT_WIDTH since pot_q < THRESHOLD
    always_comb begin
        pot_sum = pot_q;
        for (int i = 0; i < NUM_INP; i++) begin
            if (net_spikes[i]) begin
                pot_sum = pot_sum + WEIGHTS[NRN_IDX][i];
            end
        end
    end

    // fire at or above threshold, otherwise keep the sum
    // negative sums fall back to zero
    always_comb begin
        fire = (pot_sum >= THRESHOLD);
        if (fire) begin
            pot_nxt = '0;
        end else if (pot_sum < 0) begin
            pot_nxt = '0;
        end else begin
            pot_nxt = pot_sum;
        end
    end

    // update only on the edge that closes a step cycle
    // a clear in the same cycle holds the neuron in reset,
    // so clear wins over a coincident step
    always_ff @(posedge clk or negedge nrn_arstn) begin
        if (!nrn_arstn) begin
            pot_q <= '0;
            spike <= 1'b0;
        end else if (net_step) begin
            pot_q <= pot_nxt;
            spike <= fire;
        end
    end

endmodule

// ==== src/network_sink.sv ====
/*
 * Output side of the network
 * captures clear and sync events until reported
 * forms the output packet from flags and neuron spikes
 * passes host back-pressure to the source
 */

`timescale 1ns/1ps

module network_sink
    import snn_pkg::*;
(
    input  logic                clk,
    input  logic                arstn,
    // handshake with the source
    input  logic                net_sync,
    output logic                net_ready,
    // network side
    input  logic                net_arstn,
    input  logic                net_en,
    input  logic [NUM_OUT-1:0]  net_out,
    // host stream
    input  logic                snk_ready,
    output logic                snk_valid,
    output out_pkt_t            snk
);

    // pending events, each reported once
    logic                     clr_q;
    logic                     snc_q;

    // output handshake on this edge
    logic                     deliver;

    // packet assembled by bit position
    logic [PKT_OUT_WIDTH-1:0] snk_word;

    // source may only go ahead when the host can take a result
    assign net_ready = snk_ready;

    // a finished step is the output packet
    assign snk_valid = net_en;
    assign deliver   = snk_valid && snk_ready;

    // clear pulse seen, global reset is not reported as a clear
    // capture sits on the edge that ends the pulse, before any valid
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            clr_q <= 1'b0;
        end else if (!net_arstn) begin
            clr_q <= 1'b1;
        end else if (deliver) begin
            clr_q <= 1'b0;
        end
    end

    // sync pulse seen
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            snc_q <= 1'b0;
        end else if (net_sync) begin
            snc_q <= 1'b1;
        end else if (deliver) begin
            snc_q <= 1'b0;
        end
    end

    // flags by position, spikes in the low bits
    always_comb begin
        snk_word                        = '0;
        snk_word[PKT_OUT_WIDTH-1-RUN]   = 1'b0;
        snk_word[PKT_OUT_WIDTH-1-SNC]   = snc_q;
        snk_word[PKT_OUT_WIDTH-1-CLR]   = clr_q;
        snk_word[NUM_OUT-1:0]           = net_out;
    end

    // holds while valid, flags and spikes only move on a handshake
    assign snk = out_pkt_t'(snk_word);

endmodule

// ==== src/snn_top.sv ====
/*
 * Spiking network processor top level
 * network source, bank of neurons, network sink
 */

`timescale 1ns/1ps

module snn_top
    import snn_pkg::*;
(
    input  logic      clk,
    input  logic      arstn,
    // input packets
    input  logic      src_valid,
    output logic      src_ready,
    input  in_pkt_t   src,
    // output packets
    input  logic      snk_ready,
    output logic      snk_valid,
    output out_pkt_t  snk
);

    // source to neurons
    logic [NUM_INP-1:0] net_spikes;
    logic               net_step;
    logic               net_arstn;

    // source to sink
    logic               net_sync;
    logic               net_en;
    logic               net_ready;

    // neurons to sink
    logic [NUM_OUT-1:0] net_out;

    network_source source_i (
        .clk        (clk),
        .arstn      (arstn),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src        (src),
        .net_ready  (net_ready),
        .net_spikes (net_spikes),
        .net_step   (net_step),
        .net_sync   (net_sync),
        .net_arstn  (net_arstn),
        .net_en     (net_en)
    );

    // one neuron per network output, each on its own weight row
    for (genvar n = 0; n < NUM_OUT; n++) begin : g_nrn
        lif_neuron #(
            .NRN_IDX (n)
        ) nrn_i (
            .clk        (clk),
            .arstn      (arstn),
            .net_arstn  (net_arstn),
            .net_step   (net_step),
            .net_spikes (net_spikes),
            .spike      (net_out[n])
        );
    end

    network_sink sink_i (
        .clk        (clk),
        .arstn      (arstn),
        .net_sync   (net_sync),
        .net_ready  (net_ready),
        .net_arstn  (net_arstn),
        .net_en     (net_en),
        .net_out    (net_out),
        .snk_ready  (snk_ready),
        .snk_valid  (snk_valid),
        .snk        (snk)
    );

endmodule

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock and reset generator
 * free-running clock, active-low reset held for a few cycles
 */

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic arstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lands mid-cycle, clear of the active edge
    initial begin
        arstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
    end

endmodule

// ==== bench/tb_snn.sv ====
/*
 * Testbench for the spiking network processor
 * packet stimulus, random output back-pressure
 * packet-level reference model of the neuron bank
 * output monitor with assertions, per-test report
 */

`timescale 1ns/1ps

module tb_snn
    import snn_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int RDY_LEN    = 256;
    localparam int RND_PKTS   = 40;

    logic               clk;
    logic               arstn;
    logic               src_valid;
    logic               src_ready;
    in_pkt_t            src;
    logic               snk_ready;
    logic               snk_valid;
    out_pkt_t           snk;

    // reference model of potentials, held spikes and pending events
    int                 exp_pot [NUM_OUT];
    logic [NUM_OUT-1:0] exp_spk;
    logic               pend_clr;
    logic               pend_snc;
    out_pkt_t           exp_q [$];

    // bookkeeping
    string              cur_test;
    int                 err_count;
    int                 test_err;
    int                 test_count;
    int                 fail_count;
    int                 check_count;
    int                 run_count;
    int                 out_count;

    // ready pattern for the random test, drawn before it starts
    integer             seed;
    logic               rand_ready;
    logic               ready_pat [RDY_LEN];
    int                 rdy_idx;

    // monitor state
    logic               stalled;
    logic               in_hs;
    out_pkt_t           held_pkt;
    out_pkt_t           exp_pkt;

    tb_clock #(
        .PERIOD_NS  (20),
        .RST_CYCLES (4)
    ) clock_i (
        .clk   (clk),
        .arstn (arstn)
    );

    snn_top dut_i (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src       (src),
        .snk_ready (snk_ready),
        .snk_valid (snk_valid),
        .snk       (snk)
    );

    function automatic void report_mismatch(input string what, input logic [31:0] exp_v,
                                            input logic [31:0] act_v);
        $display("mismatch %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
        err_count++;
    endfunction

    function automatic void report_fail(input string what);
        $display("error in %s: %s", cur_test, what);
        err_count++;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout in %s: %s", cur_test, what);
        $display("Some tests failed");
        $finish;
    endtask

    // packet taken on the coming edge
    // clear wins over a step in the same packet
    function automatic void model_accept(input in_pkt_t p);
        int       sum;
        out_pkt_t o;
        if (p.flg.clr) begin
            for (int n = 0; n < NUM_OUT; n++) exp_pot[n] = 0;
            exp_spk  = '0;
            pend_clr = 1'b1;
        end
        if (p.flg.snc) pend_snc = 1'b1;
        if (p.flg.run && !p.flg.clr) begin
            for (int n = 0; n < NUM_OUT; n++) begin
                sum = exp_pot[n];
                for (int i = 0; i < NUM_INP; i++) begin
                    if (p.spikes[i]) sum += WEIGHTS[n][i];
                end
                // fire and restart or keep the sum clamped at zero
                exp_spk[n] = (sum >= int'(THRESHOLD));
                exp_pot[n] = (exp_spk[n] || sum < 0) ? 0 : sum;
            end
        end
        if (p.flg.run) begin
            o.flg.run = 1'b0;
            o.flg.snc = pend_snc;
            o.flg.clr = pend_clr;
            o.spikes  = exp_spk;
            exp_q.push_back(o);
            pend_clr  = 1'b0;
            pend_snc  = 1'b0;
            run_count++;
        end
    endfunction

    // every run packet also checks the two-edge path to snk_valid
    task automatic send_pkt(input logic run, input logic snc, input logic clr,
                            input logic [NUM_INP-1:0] spk);
        in_pkt_t p;
        int      waited;
        int      lat;
        p.flg.run = run;
        p.flg.snc = snc;
        p.flg.clr = clr;
        p.spikes  = spk;
        waited    = 0;
        @(posedge clk);
        src       <= p;
        src_valid <= 1'b1;
        @(negedge clk);
        while (!src_ready) begin
            if (waited == WAIT_LIMIT) abort_run("src_ready stayed low");
            waited++;
            @(negedge clk);
        end
        model_accept(p);
        @(posedge clk);
        src_valid <= 1'b0;
        if (run) begin
            lat = 1;
            @(negedge clk);
            while (!snk_valid) begin
                if (lat == WAIT_LIMIT) abort_run("snk_valid never rose after a run packet");
                lat++;
                @(negedge clk);
            end
            check_count++;
            assert (lat == 2) else report_mismatch("edges to snk_valid", 2, lat);
        end
    endtask

    task automatic expect_no_output(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_count++;
            assert (!snk_valid) else report_fail("output packet after a packet without run");
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0 || snk_valid) begin
            if (waited == WAIT_LIMIT) abort_run("expected output packets never arrived");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = err_count;
        test_count++;
    endtask

    task automatic end_test();
        wait_drain();
        if (err_count == test_err) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: FAILED with %0d errors", cur_test, err_count - test_err);
            fail_count++;
        end
    endtask

    // back-pressure is random only inside the random test
    always @(posedge clk) begin
        if (rand_ready) begin
            snk_ready <= ready_pat[rdy_idx];
            rdy_idx   <= (rdy_idx + 1) % RDY_LEN;
        end else begin
            snk_ready <= 1'b1;
        end
    end

    // sampled mid-cycle so a handshake seen here completes on the next rising edge
    always @(negedge clk) begin
        if (stalled) begin
            check_count++;
            assert (snk_valid) else report_fail("snk_valid dropped before the handshake");
            assert (snk == held_pkt) else report_mismatch("held packet", held_pkt, snk);
        end
        if (snk_valid && snk_ready) begin
            check_count++;
            assert (exp_q.size() > 0) else report_fail("output packet with no run packet");
            if (exp_q.size() > 0) begin
                exp_pkt = exp_q.pop_front();
                assert (snk == exp_pkt) else report_mismatch("output packet", exp_pkt, snk);
            end
            out_count++;
        end
        // input side is ready only with the output open and no packet in flight
        if (src_ready) begin
            check_count++;
            assert (snk_ready && !in_hs)
                else report_fail("src_ready high while the output is blocked or busy");
        end
        stalled  = snk_valid && !snk_ready;
        in_hs    = src_valid && src_ready;
        held_pkt = snk;
    end

    initial begin
        int          waited;
        int          runs_before;
        int          outs_before;
        logic [31:0] rnd;
        seed       = 32'h2b3f50fe;
        stalled    = 1'b0;
        in_hs      = 1'b0;
        exp_spk    = '0;
        pend_clr   = 1'b0;
        pend_snc   = 1'b0;
        for (int n = 0; n < NUM_OUT; n++) exp_pot[n] = 0;
        src_valid  <= 1'b0;
        src        <= '0;
        snk_ready  <= 1'b1;
        rand_ready <= 1'b0;
        rdy_idx    <= 0;
        cur_test   = "reset";
        waited     = 0;
        while (arstn !== 1'b1) begin
            if (waited == WAIT_LIMIT) abort_run("reset never released");
            waited++;
            @(negedge clk);
        end

        // all inputs from zero potentials let only neuron 0 reach 8
        start_test("reset_first_run");
        send_pkt(1'b1, 1'b0, 1'b0, 4'b1111);
        end_test();

        // input 0 alone fires neuron 1 every 2nd step and neuron 0 every 3rd
        // neuron 3 first fires on the 8th step
        start_test("integrate_to_threshold");
        send_pkt(1'b0, 1'b0, 1'b1, 4'b0000);
        repeat (9) send_pkt(1'b1, 1'b0, 1'b0, 4'b0001);
        end_test();

        start_test("clear_once");
        send_pkt(1'b1, 1'b0, 1'b0, 4'b0110);
        send_pkt(1'b0, 1'b0, 1'b1, 4'b1111);
        expect_no_output(4);
        send_pkt(1'b1, 1'b0, 1'b0, 4'b1010);
        send_pkt(1'b1, 1'b0, 1'b0, 4'b1010);
        end_test();

        // sync alone waits for the next run
        // all three flags together report in their own packet
        start_test("sync_and_flags");
        send_pkt(1'b0, 1'b1, 1'b0, 4'b0000);
        expect_no_output(4);
        send_pkt(1'b1, 1'b0, 1'b0, 4'b0011);
        send_pkt(1'b1, 1'b0, 1'b0, 4'b0011);
        send_pkt(1'b1, 1'b1, 1'b1, 4'b1111);
        send_pkt(1'b1, 1'b0, 1'b0, 4'b0100);
        end_test();

        start_test("random_ready");
        for (int i = 0; i < RDY_LEN; i++) begin
            rnd          = $random(seed);
            ready_pat[i] = (rnd[1:0] != 2'b00);
        end
        runs_before = run_count;
        outs_before = out_count;
        rand_ready <= 1'b1;
        for (int i = 0; i < RND_PKTS; i++) begin
            rnd = $random(seed);
            send_pkt(rnd[9:8] != 2'b00, rnd[4], rnd[7:5] == 3'b000, rnd[3:0]);
        end
        wait_drain();
        rand_ready <= 1'b0;
        check_count++;
        assert (out_count - outs_before == run_count - runs_before)
            else report_mismatch("output count", run_count - runs_before, out_count - outs_before);
        end_test();

        check_count++;
        assert (out_count == run_count) else report_mismatch("total outputs", run_count, out_count);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, fail_count, check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/snn_pkg.sv
src/network_source.sv
src/lif_neuron.sv
src/network_sink.sv
src/snn_top.sv
bench/tb_clock.sv
bench/tb_snn.sv

// ==== Bender.yml ====
package:
  name: snn_proc

sources:
  # design, package first
  - files:
      - src/snn_pkg.sv
      - src/network_source.sv
      - src/lif_neuron.sv
      - src/network_sink.sv
      - src/snn_top.sv

  # testbench, top module tb_snn
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_snn.sv
